// File: design/iopage_pkg.sv
// Addresses are 13-bit I/O page byte offsets. Only word registers exist and address bit 0 is ignored.
package iopage_pkg;

   // Register addresses, in octal as the processor handbook lists them.
   localparam logic [12:0] addr_mmr0 = 13'o17572;
   localparam logic [12:0] addr_mmr1 = 13'o17574;
   localparam logic [12:0] addr_mmr2 = 13'o17576;
   localparam logic [12:0] addr_mmr3 = 13'o17516;
   localparam logic [12:0] addr_lclk = 13'o17546;

   localparam logic [7:0] vector_lclk = 8'o100;

   // AXI response codes used by the bridge.
   localparam logic [1:0] axi_resp_okay   = 2'b00;
   localparam logic [1:0] axi_resp_slverr = 2'b10;

   // One I/O page bus cycle. At most one of rd and wr is high.
   typedef struct packed {
      logic [12:0] addr;
      logic [15:0] wdata;
      logic [1:0]  byte_en;
      logic        rd;
      logic        wr;
      logic        byte_op;
   } iopage_cycle_t;

   // The answer of one device on the I/O page.
   typedef struct packed {
      logic [15:0] rdata;
      logic        decode;
      logic        interrupt;
      logic [7:0]  vector;
   } iopage_resp_t;

endpackage

// File: design/mmu_pkg.sv
// MMR0 layout of the PDP-11 memory management unit. Reserved bits always read as zero.
package mmu_pkg;

   // MMR0 seen as its fields, most significant first.
   typedef struct packed {
      logic [2:0] abort;
      logic [3:0] reserved_hi;
      logic       maint;
      logic       reserved_lo;
      logic [1:0] mode;
      logic [3:0] page;
      logic       enable;
   } mmr0_fields_t;

   // The same word seen raw, for byte merging, or as fields.
   typedef union packed {
      logic [15:0]  raw;
      mmr0_fields_t f;
   } mmr0_word_u;

   // Abort flags, maintenance, mode, page and enable are writable.
   localparam logic [15:0] mmr0_write_mask = 16'b1110_0001_0111_1111;

   // MMR3 bit that turns on 22-bit mapping.
   localparam int unsigned mmr3_enable_22 = 4;

endpackage

// File: design/axil_iopage_bridge.sv
// One AXI4-Lite transaction at a time. Uses data bits 15:0, strobes 1:0 and address bits 12:1.
module axil_iopage_bridge
   import iopage_pkg::*;
(
   input  logic          clk,
   input  logic          reset,

   input  logic [15:0]   awaddr,
   input  logic          awvalid,
   output logic          awready,
   input  logic [31:0]   wdata,
   input  logic [3:0]    wstrb,
   input  logic          wvalid,
   output logic          wready,
   output logic [1:0]    bresp,
   output logic          bvalid,
   input  logic          bready,

   input  logic [15:0]   araddr,
   input  logic          arvalid,
   output logic          arready,
   output logic [31:0]   rdata,
   output logic [1:0]    rresp,
   output logic          rvalid,
   input  logic          rready,

   output iopage_cycle_t cycle,
   input  logic [15:0]   rdata_bus,
   input  logic          no_decode
);

   typedef enum logic [1:0] {
      st_idle,
      st_bus,
      st_respond
   } state_t;

   state_t state;
   logic   take_write;
   logic   take_read;

   // A write wins when both channels ask in the same cycle.
   assign take_write = (state == st_idle) && awvalid && wvalid;
   assign take_read  = (state == st_idle) && arvalid && !take_write;

   assign awready = take_write;
   assign wready  = take_write;
   assign arready = take_read;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state    <= st_idle;
         cycle.rd <= 1'b0;
         cycle.wr <= 1'b0;
         bvalid   <= 1'b0;
         rvalid   <= 1'b0;
      end
      else
      begin
         case (state)
            st_idle:
            begin
               if (take_write)
               begin
                  cycle.addr    <= {awaddr[12:1], 1'b0};
                  cycle.wdata   <= wdata[15:0];
                  cycle.byte_en <= wstrb[1:0];
                  cycle.byte_op <= ~&wstrb[1:0];
                  cycle.wr      <= 1'b1;
                  state         <= st_bus;
               end
               else if (take_read)
               begin
                  cycle.addr    <= {araddr[12:1], 1'b0};
                  cycle.byte_en <= 2'b11;
                  cycle.byte_op <= 1'b0;
                  cycle.rd      <= 1'b1;
                  state         <= st_bus;
               end
            end

            st_bus:
            begin
               // The devices see rd or wr for this one cycle only.
               cycle.rd <= 1'b0;
               cycle.wr <= 1'b0;
               if (cycle.wr)
               begin
                  bvalid <= 1'b1;
                  bresp  <= no_decode ? axi_resp_slverr : axi_resp_okay;
               end
               if (cycle.rd)
               begin
                  rvalid <= 1'b1;
                  rresp  <= no_decode ? axi_resp_slverr : axi_resp_okay;
                  rdata  <= no_decode ? 32'h0 : {16'h0, rdata_bus};
               end
               state <= st_respond;
            end

            st_respond:
            begin
               if ((bvalid && bready) || (rvalid && rready))
               begin
                  bvalid <= 1'b0;
                  rvalid <= 1'b0;
                  state  <= st_idle;
               end
            end

            default:
               state <= st_idle;
         endcase
      end
   end

endmodule

// File: design/mmu_regs.sv
// MMR0 to MMR3 only. No address translation here, and MMR1 and MMR2 hold garbage until written.
module mmu_regs
   import iopage_pkg::*;
   import mmu_pkg::*;
(
   input  logic          clk,
   input  logic          reset,
   input  iopage_cycle_t cycle,
   output iopage_resp_t  resp,
   output logic          mmu_enable,
   output logic          mmu_22bit
);

   mmr0_word_u  mmr0;
   logic [15:0] mmr1;
   logic [15:0] mmr2;
   logic [15:0] mmr3;
   logic        sel_mmr0;
   logic        sel_mmr1;
   logic        sel_mmr2;
   logic        sel_mmr3;

   // Replace only the enabled bytes of a register.
   function automatic logic [15:0] merge_bytes(input logic [15:0] old_word,
                                               input logic [15:0] new_word,
                                               input logic [1:0]  byte_en,
                                               input logic        byte_op);
      logic [1:0] en;
      en = byte_op ? byte_en : 2'b11;
      merge_bytes = old_word;
      if (en[0])
         merge_bytes[7:0] = new_word[7:0];
      if (en[1])
         merge_bytes[15:8] = new_word[15:8];
   endfunction

   assign sel_mmr0 = (cycle.addr == addr_mmr0);
   assign sel_mmr1 = (cycle.addr == addr_mmr1);
   assign sel_mmr2 = (cycle.addr == addr_mmr2);
   assign sel_mmr3 = (cycle.addr == addr_mmr3);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         mmr0.raw <= 16'h0;
         mmr3     <= 16'h0;
      end
      else if (cycle.wr)
      begin
         // Masking keeps the reserved fields of MMR0 at zero.
         if (sel_mmr0)
            mmr0.raw <= merge_bytes(mmr0.raw, cycle.wdata, cycle.byte_en, cycle.byte_op)
                        & mmr0_write_mask;
         if (sel_mmr3)
            mmr3 <= merge_bytes(mmr3, cycle.wdata, cycle.byte_en, cycle.byte_op);
      end
   end

   always_ff @(posedge clk)
   begin
      if (cycle.wr && sel_mmr1)
         mmr1 <= merge_bytes(mmr1, cycle.wdata, cycle.byte_en, cycle.byte_op);
      if (cycle.wr && sel_mmr2)
         mmr2 <= merge_bytes(mmr2, cycle.wdata, cycle.byte_en, cycle.byte_op);
   end

   always_comb
   begin
      resp.decode    = sel_mmr0 | sel_mmr1 | sel_mmr2 | sel_mmr3;
      resp.interrupt = 1'b0;
      resp.vector    = 8'h0;
      resp.rdata     = 16'h0;
      if (sel_mmr0)
         resp.rdata = mmr0.raw;
      else if (sel_mmr1)
         resp.rdata = mmr1;
      else if (sel_mmr2)
         resp.rdata = mmr2;
      else if (sel_mmr3)
         resp.rdata = mmr3;
   end

   assign mmu_enable = mmr0.f.enable;
   assign mmu_22bit  = mmr3[mmr3_enable_22];

endmodule

// File: design/line_clock_regs.sv
// KW11-L status register only. The request is a level held until software clears the monitor.
module line_clock_regs
   import iopage_pkg::*;
(
   input  logic          clk,
   input  logic          reset,
   input  iopage_cycle_t cycle,
   input  logic          line_tick,
   output iopage_resp_t  resp
);

   logic decode;
   logic low_byte_wr;
   logic monitor;
   logic int_enable;

   assign decode = (cycle.addr == addr_lclk);

   // Both status bits live in the low byte.
   assign low_byte_wr = cycle.wr && decode && (!cycle.byte_op || cycle.byte_en[0]);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         monitor    <= 1'b0;
         int_enable <= 1'b0;
      end
      else
      begin
         if (low_byte_wr)
         begin
            // A tick in the same cycle keeps the flag set.
            monitor    <= cycle.wdata[7] | line_tick;
            int_enable <= cycle.wdata[6];
         end
         else if (line_tick)
         begin
            monitor <= 1'b1;
         end
      end
   end

   always_comb
   begin
      resp.decode    = decode;
      resp.rdata     = {8'h0, monitor, int_enable, 6'h0};
      resp.interrupt = monitor & int_enable;
      resp.vector    = vector_lclk;
   end

endmodule

// File: design/iopage_mux.sv
// Combinational merge of two devices. The mmu has interrupt priority over the line clock.
module iopage_mux
   import iopage_pkg::*;
(
   input  iopage_cycle_t cycle,
   input  iopage_resp_t  mmu_resp,
   input  iopage_resp_t  lclk_resp,
   output logic [15:0]   rdata_bus,
   output logic          no_decode,
   output logic          interrupt,
   output logic [7:0]    vector
);

   logic any_decode;

   assign any_decode = mmu_resp.decode | lclk_resp.decode;

   // An access that no device claims ends as a bus error.
   assign no_decode = (cycle.rd | cycle.wr) & ~any_decode;

   always_comb
   begin
      if (mmu_resp.decode)
         rdata_bus = mmu_resp.rdata;
      else if (lclk_resp.decode)
         rdata_bus = lclk_resp.rdata;
      else
         rdata_bus = 16'h0;
   end

   assign interrupt = mmu_resp.interrupt | lclk_resp.interrupt;

   always_comb
   begin
      if (mmu_resp.interrupt)
         vector = mmu_resp.vector;
      else if (lclk_resp.interrupt)
         vector = lclk_resp.vector;
      else
         vector = 8'h0;
   end

endmodule

// File: design/iopage_top.sv
// I/O page slice with MMU and line clock registers. No acknowledge, so the vector is valid with interrupt.
module iopage_top
   import iopage_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic [15:0] awaddr,
   input  logic        awvalid,
   output logic        awready,
   input  logic [31:0] wdata,
   input  logic [3:0]  wstrb,
   input  logic        wvalid,
   output logic        wready,
   output logic [1:0]  bresp,
   output logic        bvalid,
   input  logic        bready,
   input  logic [15:0] araddr,
   input  logic        arvalid,
   output logic        arready,
   output logic [31:0] rdata,
   output logic [1:0]  rresp,
   output logic        rvalid,
   input  logic        rready,
   input  logic        line_tick,
   output logic        interrupt,
   output logic [7:0]  vector,
   output logic        mmu_enable,
   output logic        mmu_22bit
);

   iopage_cycle_t cycle;
   iopage_resp_t  mmu_resp;
   iopage_resp_t  lclk_resp;
   logic [15:0]   rdata_bus;
   logic          no_decode;

   axil_iopage_bridge bridge1(.clk(clk), .reset(reset),
                              .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
                              .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
                              .bresp(bresp), .bvalid(bvalid), .bready(bready),
                              .araddr(araddr), .arvalid(arvalid), .arready(arready),
                              .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
                              .cycle(cycle), .rdata_bus(rdata_bus), .no_decode(no_decode));

   mmu_regs mmu_regs1(.clk(clk), .reset(reset), .cycle(cycle), .resp(mmu_resp),
                      .mmu_enable(mmu_enable), .mmu_22bit(mmu_22bit));

   line_clock_regs lclk_regs1(.clk(clk), .reset(reset), .cycle(cycle),
                              .line_tick(line_tick), .resp(lclk_resp));

   iopage_mux mux1(.cycle(cycle), .mmu_resp(mmu_resp), .lclk_resp(lclk_resp),
                   .rdata_bus(rdata_bus), .no_decode(no_decode),
                   .interrupt(interrupt), .vector(vector));

endmodule

// File: bench/iopage_tb.sv
// Runs one AXI4-Lite access at a time from a table. Random bready and rready delays use seed 61674.
module iopage_tb
   import iopage_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam logic [1:0]  op_write      = 2'd0;
   localparam logic [1:0]  op_read       = 2'd1;
   localparam logic [1:0]  op_tick       = 2'd2;
   localparam logic [1:0]  resp_okay     = 2'b00;
   localparam logic [1:0]  resp_slverr   = 2'b10;
   localparam logic [12:0] addr_none     = 13'o17500;
   localparam logic [7:0]  lclk_vector   = 8'o100;
   localparam logic [15:0] mmr0_readback = 16'hE17F;

   // One table row: the access and what the DUT must answer.
   typedef struct packed {
      logic [1:0]  op;
      logic [15:0] addr;
      logic [15:0] data;
      logic [1:0]  strb;
      logic [15:0] exp_data;
      logic [1:0]  exp_resp;
      logic        exp_int;
      logic [7:0]  exp_vec;
      logic        exp_enable;
      logic        exp_22bit;
   } step_t;

   logic        clk;
   logic        reset;
   logic [15:0] awaddr;
   logic        awvalid;
   logic        awready;
   logic [31:0] wdata;
   logic [3:0]  wstrb;
   logic        wvalid;
   logic        wready;
   logic [1:0]  bresp;
   logic        bvalid;
   logic        bready;
   logic [15:0] araddr;
   logic        arvalid;
   logic        arready;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   logic        rvalid;
   logic        rready;
   logic        line_tick;
   logic        interrupt;
   logic [7:0]  vector;
   logic        mmu_enable;
   logic        mmu_22bit;

   step_t       steps[$];
   logic        exp_int_now;
   logic        exp_enable_now;
   logic        exp_22bit_now;
   logic [15:0] mmr1_exp;
   logic [15:0] mmr2_exp;
   logic [15:0] mmr3_exp;
   logic        bvalid_q;
   logic        rvalid_q;
   int          error_count = 0;
   int          cycle_count = 0;
   int          cycle_limit = 0;
   int          writes_accepted = 0;
   int          writes_done = 0;
   int          reads_accepted = 0;
   int          reads_done = 0;
   int          writes_answered = 0;
   int          reads_answered = 0;
   int          writes_issued = 0;
   int          reads_issued = 0;

   iopage_top iopage_top_i(.clk(clk), .reset(reset),
                           .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
                           .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
                           .bresp(bresp), .bvalid(bvalid), .bready(bready),
                           .araddr(araddr), .arvalid(arvalid), .arready(arready),
                           .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
                           .line_tick(line_tick), .interrupt(interrupt), .vector(vector),
                           .mmu_enable(mmu_enable), .mmu_22bit(mmu_22bit));

   initial
   begin
      clk = 1'b0;
      forever
         #5 clk = ~clk;
   end

   // Handshakes are counted at the rising edge, where the DUT samples them.
   always @(posedge clk)
   begin
      if (reset)
      begin
         writes_accepted <= 0;
         writes_done     <= 0;
         reads_accepted  <= 0;
         reads_done      <= 0;
         writes_answered <= 0;
         reads_answered  <= 0;
         bvalid_q        <= 1'b0;
         rvalid_q        <= 1'b0;
      end
      else
      begin
         bvalid_q <= bvalid;
         rvalid_q <= rvalid;
         if (awvalid && awready && wvalid && wready)
            writes_accepted <= writes_accepted + 1;
         if (bvalid && bready)
            writes_done <= writes_done + 1;
         if (arvalid && arready)
            reads_accepted <= reads_accepted + 1;
         if (rvalid && rready)
            reads_done <= reads_done + 1;
         // A response is counted once, when its valid rises.
         if (bvalid && !bvalid_q)
            writes_answered <= writes_answered + 1;
         if (rvalid && !rvalid_q)
            reads_answered <= reads_answered + 1;
      end
   end

   initial
   begin
      wait (cycle_limit > 0);
      while (cycle_count < cycle_limit)
      begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Timeout after %0d cycles, the DUT stopped answering and the run hung.",
               cycle_limit);
      $display("Simulation FAILED");
      $finish;
   end

   task automatic compare_value(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
      if (actual !== expected)
      begin
         $display("ERROR %s: got %h, expected %h at %0t", name, actual, expected, $time);
         error_count++;
      end
   endtask

   function automatic logic [15:0] merge_strobed(input logic [15:0] old_word,
                                                 input logic [15:0] new_word,
                                                 input logic [1:0]  strb);
      logic [15:0] result;
      result = old_word;
      if (strb[0])
         result[7:0] = new_word[7:0];
      if (strb[1])
         result[15:8] = new_word[15:8];
      return result;
   endfunction

   function automatic void add_row(input logic [1:0] op, input logic [12:0] addr,
                                   input logic [15:0] data, input logic [1:0] strb,
                                   input logic [15:0] exp_data, input logic [1:0] exp_resp);
      step_t s;
      s.op         = op;
      s.addr       = {3'b000, addr};
      s.data       = data;
      s.strb       = strb;
      s.exp_data   = exp_data;
      s.exp_resp   = exp_resp;
      s.exp_int    = exp_int_now;
      s.exp_vec    = exp_int_now ? lclk_vector : 8'h00;
      s.exp_enable = exp_enable_now;
      s.exp_22bit  = exp_22bit_now;
      steps.push_back(s);
   endfunction

   task automatic build_steps();
      logic [15:0] rand_word;
      exp_int_now    = 1'b0;
      exp_enable_now = 1'b0;
      exp_22bit_now  = 1'b0;
      add_row(op_read, addr_mmr0, 16'h0, 2'b11, 16'h0000, resp_okay);
      add_row(op_read, addr_mmr3, 16'h0, 2'b11, 16'h0000, resp_okay);
      add_row(op_read, addr_lclk, 16'h0, 2'b11, 16'h0000, resp_okay);
      // Full word writes.
      exp_enable_now = 1'b1;
      add_row(op_write, addr_mmr0, 16'hFFFF, 2'b11, 16'h0, resp_okay);
      add_row(op_read, addr_mmr0, 16'h0, 2'b11, mmr0_readback, resp_okay);
      exp_22bit_now = 1'b1;
      mmr3_exp = 16'h0010;
      add_row(op_write, addr_mmr3, mmr3_exp, 2'b11, 16'h0, resp_okay);
      add_row(op_read, addr_mmr3, 16'h0, 2'b11, mmr3_exp, resp_okay);
      mmr1_exp = 16'($urandom);
      add_row(op_write, addr_mmr1, mmr1_exp, 2'b11, 16'h0, resp_okay);
      add_row(op_read, addr_mmr1, 16'h0, 2'b11, mmr1_exp, resp_okay);
      mmr2_exp = 16'($urandom);
      add_row(op_write, addr_mmr2, mmr2_exp, 2'b11, 16'h0, resp_okay);
      add_row(op_read, addr_mmr2, 16'h0, 2'b11, mmr2_exp, resp_okay);
      // Byte writes keep the other byte.
      rand_word = 16'($urandom);
      mmr1_exp = merge_strobed(mmr1_exp, rand_word, 2'b01);
      add_row(op_write, addr_mmr1, rand_word, 2'b01, 16'h0, resp_okay);
      add_row(op_read, addr_mmr1, 16'h0, 2'b11, mmr1_exp, resp_okay);
      rand_word = 16'($urandom);
      mmr1_exp = merge_strobed(mmr1_exp, rand_word, 2'b10);
      add_row(op_write, addr_mmr1, rand_word, 2'b10, 16'h0, resp_okay);
      add_row(op_read, addr_mmr1, 16'h0, 2'b11, mmr1_exp, resp_okay);
      mmr3_exp = merge_strobed(mmr3_exp, 16'hA5FF, 2'b10);
      add_row(op_write, addr_mmr3, 16'hA5FF, 2'b10, 16'h0, resp_okay);
      add_row(op_read, addr_mmr3, 16'h0, 2'b11, mmr3_exp, resp_okay);
      exp_22bit_now = 1'b0;
      mmr3_exp = merge_strobed(mmr3_exp, 16'h5A00, 2'b01);
      add_row(op_write, addr_mmr3, 16'h5A00, 2'b01, 16'h0, resp_okay);
      add_row(op_read, addr_mmr3, 16'h0, 2'b11, mmr3_exp, resp_okay);
      // Nobody decodes 17500, so both accesses fail and nothing changes.
      add_row(op_write, addr_none, 16'h1234, 2'b11, 16'h0, resp_slverr);
      add_row(op_read, addr_none, 16'h0, 2'b11, 16'h0000, resp_slverr);
      add_row(op_read, addr_mmr0, 16'h0, 2'b11, mmr0_readback, resp_okay);
      add_row(op_read, addr_mmr1, 16'h0, 2'b11, mmr1_exp, resp_okay);
      add_row(op_read, addr_mmr3, 16'h0, 2'b11, mmr3_exp, resp_okay);
      // Line clock monitor and interrupt enable.
      add_row(op_tick, 13'h0, 16'h0, 2'b00, 16'h0, resp_okay);
      add_row(op_read, addr_lclk, 16'h0, 2'b11, 16'h0080, resp_okay);
      exp_int_now = 1'b1;
      add_row(op_write, addr_lclk, 16'h00C0, 2'b11, 16'h0, resp_okay);
      add_row(op_read, addr_lclk, 16'h0, 2'b11, 16'h00C0, resp_okay);
      exp_int_now = 1'b0;
      add_row(op_write, addr_lclk, 16'h0040, 2'b11, 16'h0, resp_okay);
      add_row(op_read, addr_lclk, 16'h0, 2'b11, 16'h0040, resp_okay);
      exp_int_now = 1'b1;
      add_row(op_tick, 13'h0, 16'h0, 2'b00, 16'h0, resp_okay);
      add_row(op_read, addr_lclk, 16'h0, 2'b11, 16'h00C0, resp_okay);
      exp_int_now = 1'b0;
      add_row(op_write, addr_lclk, 16'h0000, 2'b11, 16'h0, resp_okay);
      add_row(op_read, addr_lclk, 16'h0, 2'b11, 16'h0000, resp_okay);
      for (int i = 0; i < 6; i++)
      begin
         mmr2_exp = 16'($urandom);
         add_row(op_write, addr_mmr2, mmr2_exp, 2'b11, 16'h0, resp_okay);
         add_row(op_read, addr_mmr2, 16'h0, 2'b11, mmr2_exp, resp_okay);
      end
   endtask

   task automatic apply_write(input step_t s);
      int start;
      int delay;
      start = writes_accepted;
      awaddr = s.addr;
      wdata = {16'h0000, s.data};
      wstrb = {2'b00, s.strb};
      awvalid = 1'b1;
      wvalid = 1'b1;
      while (writes_accepted == start)
         @(negedge clk);
      awvalid = 1'b0;
      wvalid = 1'b0;
      while (!bvalid)
         @(negedge clk);
      delay = $urandom_range(3, 0);
      repeat (delay)
         @(negedge clk);
      compare_value("bvalid", 32'(bvalid), 32'd1);
      compare_value("bresp", 32'(bresp), 32'(s.exp_resp));
      start = writes_done;
      bready = 1'b1;
      while (writes_done == start)
         @(negedge clk);
      bready = 1'b0;
   endtask

   task automatic apply_read(input step_t s);
      int start;
      int delay;
      start = reads_accepted;
      araddr = s.addr;
      arvalid = 1'b1;
      while (reads_accepted == start)
         @(negedge clk);
      arvalid = 1'b0;
      while (!rvalid)
         @(negedge clk);
      delay = $urandom_range(3, 0);
      repeat (delay)
         @(negedge clk);
      compare_value("rvalid", 32'(rvalid), 32'd1);
      compare_value("rresp", 32'(rresp), 32'(s.exp_resp));
      compare_value("rdata", rdata, {16'h0000, s.exp_data});
      start = reads_done;
      rready = 1'b1;
      while (reads_done == start)
         @(negedge clk);
      rready = 1'b0;
   endtask

   task automatic pulse_tick();
      line_tick = 1'b1;
      @(negedge clk);
      line_tick = 1'b0;
   endtask

   initial
   begin
      int unsigned seed_result;
      reset = 1'b1;
      awaddr = 16'h0;
      awvalid = 1'b0;
      wdata = 32'h0;
      wstrb = 4'h0;
      wvalid = 1'b0;
      bready = 1'b0;
      araddr = 16'h0;
      arvalid = 1'b0;
      rready = 1'b0;
      line_tick = 1'b0;
      seed_result = $urandom(61674);
      build_steps();
      cycle_limit = 40 * steps.size() + 100;
      repeat (4)
         @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      foreach (steps[i])
      begin
         case (steps[i].op)
            op_write:
            begin
               apply_write(steps[i]);
               writes_issued++;
            end
            op_read:
            begin
               apply_read(steps[i]);
               reads_issued++;
            end
            op_tick:
               pulse_tick();
            default:
            begin
               $display("Step %0d holds an unknown operation and was skipped.", i);
               error_count++;
            end
         endcase
         compare_value("interrupt", 32'(interrupt), 32'(steps[i].exp_int));
         if (steps[i].exp_int)
            compare_value("vector", 32'(vector), 32'(steps[i].exp_vec));
         compare_value("mmu_enable", 32'(mmu_enable), 32'(steps[i].exp_enable));
         compare_value("mmu_22bit", 32'(mmu_22bit), 32'(steps[i].exp_22bit));
      end

      // Every access must have exactly one response.
      compare_value("writes_answered", 32'(writes_answered), 32'(writes_issued));
      compare_value("reads_answered", 32'(reads_answered), 32'(reads_issued));

      $display("Steps: %0d, writes: %0d, reads: %0d, errors: %0d",
               steps.size(), writes_issued, reads_issued, error_count);
      if (error_count == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

// File: sim.f
design/iopage_pkg.sv
design/mmu_pkg.sv
design/axil_iopage_bridge.sv
design/mmu_regs.sv
design/line_clock_regs.sv
design/iopage_mux.sv
design/iopage_top.sv
bench/iopage_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the simulation log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module iopage_tb \
   -f sim.f -o iopage_sim > build.log 2>&1 \
   && ./obj_dir/iopage_sim > sim.log 2>&1 \
   || echo "Build or simulation stopped, see build.log and sim.log"
touch sim.log
cat sim.log
grep -qx "Simulation PASSED" sim.log && exit 0 || exit 1
